// ==== Makefile ====
# Verilator build and run of the pipeline controller testbench

VERILATOR ?= verilator
TOP       ?= tb_ceres_pipe_ctrl
BUILD_DIR ?= obj_dir

SOURCES := ceres_pkg.sv hazard_unit.sv trap_unit.sv trap_csr.sv \
           ceres_pipe_ctrl.sv tb_ceres_pipe_ctrl.sv

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) sources.f
	$(VERILATOR) --binary --top-module $(TOP) -Mdir $(BUILD_DIR) -f sources.f

# Exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

// ==== ceres_pipe_ctrl.sv ====
// ==========================================================
// Ceres pipeline controller top
// Hazard unit, trap unit and trap CSR block around the
// stage facts of a five-stage RISC-V pipe
// ==========================================================
`timescale 1ns/1ps
module ceres_pipe_ctrl
  import ceres_pkg::*;
#(
  parameter int unsigned XLEN = 32
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  // Register addresses and write enables per stage
  input  logic [4:0]        r1_addr_de_i,
  input  logic [4:0]        r2_addr_de_i,
  input  logic [4:0]        r1_addr_ex_i,
  input  logic [4:0]        r2_addr_ex_i,
  input  logic [4:0]        rd_addr_ex_i,
  input  logic [4:0]        rd_addr_me_i,
  input  logic [4:0]        rd_addr_wb_i,
  input  logic              ld_ex_i,
  input  logic              rf_rw_me_i,
  input  logic              rf_rw_wb_i,
  // Branch outcome against prediction
  input  logic              br_taken_ex_i,
  input  logic              pred_taken_ex_i,
  input  logic [XLEN-1:0]   br_target_ex_i,
  input  logic [XLEN-1:0]   pred_pc_ex_i,
  input  logic [XLEN-1:0]   pc_incr_ex_i,
  // Raw stall requests
  input  logic              fencei_req_i,
  input  logic              imiss_req_i,
  input  logic              dmiss_req_i,
  input  logic              alu_req_i,
  // Stage exceptions and execute access
  input  exc_e              fe_exc_i,
  input  exc_e              de_exc_i,
  input  exc_e              alu_exc_i,
  input  logic [XLEN-1:0]   fe_pc_i,
  input  logic [XLEN-1:0]   de_pc_i,
  input  logic [XLEN-1:0]   ex_pc_i,
  input  logic              mem_valid_i,
  input  logic              mem_write_i,
  input  logic [1:0]        mem_size_i,
  input  logic [XLEN-1:0]   mem_addr_i,
  // APB
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  logic [APB_AW-1:0] paddr_i,
  input  logic [XLEN-1:0]   pwdata_i,
  output logic [XLEN-1:0]   prdata_o,
  output logic              pready_o,
  output logic              pslverr_o,
  // Pipe control
  output stall_e            stall_o,
  output logic              long_stall_o,
  output logic              flush_de_o,
  output logic              flush_ex_o,
  output fwd_e              fwd_a_ex_o,
  output fwd_e              fwd_b_ex_o,
  output logic              fwd_a_de_o,
  output logic              fwd_b_de_o,
  // Trap report and redirect
  output logic              trap_o,
  output logic [XLEN-1:0]   trap_cause_o,
  output logic [XLEN-1:0]   trap_mepc_o,
  output logic [XLEN-1:0]   trap_tval_o,
  output flush_e            trap_flush_o,
  output logic              redirect_o,
  output logic [XLEN-1:0]   redirect_pc_o,
  output logic [XLEN-1:0]   mtvec_o
);

  logic            spec_miss;
  logic [XLEN-1:0] mispredict_pc;

  hazard_unit #(
    .XLEN(XLEN)
  ) i_hazard_unit (
    .r1_addr_de_i   (r1_addr_de_i),
    .r2_addr_de_i   (r2_addr_de_i),
    .r1_addr_ex_i   (r1_addr_ex_i),
    .r2_addr_ex_i   (r2_addr_ex_i),
    .rd_addr_ex_i   (rd_addr_ex_i),
    .rd_addr_me_i   (rd_addr_me_i),
    .rd_addr_wb_i   (rd_addr_wb_i),
    .ld_ex_i        (ld_ex_i),
    .rf_rw_me_i     (rf_rw_me_i),
    .rf_rw_wb_i     (rf_rw_wb_i),
    .br_taken_ex_i  (br_taken_ex_i),
    .pred_taken_ex_i(pred_taken_ex_i),
    .br_target_ex_i (br_target_ex_i),
    .pred_pc_ex_i   (pred_pc_ex_i),
    .pc_incr_ex_i   (pc_incr_ex_i),
    .fencei_req_i   (fencei_req_i),
    .imiss_req_i    (imiss_req_i),
    .dmiss_req_i    (dmiss_req_i),
    .alu_req_i      (alu_req_i),
    .stall_o        (stall_o),
    .long_stall_o   (long_stall_o),
    .flush_de_o     (flush_de_o),
    .flush_ex_o     (flush_ex_o),
    .fwd_a_ex_o     (fwd_a_ex_o),
    .fwd_b_ex_o     (fwd_b_ex_o),
    .fwd_a_de_o     (fwd_a_de_o),
    .fwd_b_de_o     (fwd_b_de_o),
    .spec_miss_o    (spec_miss),
    .mispredict_pc_o(mispredict_pc)
  );

  trap_unit #(
    .XLEN(XLEN)
  ) i_trap_unit (
    .fe_exc_i       (fe_exc_i),
    .de_exc_i       (de_exc_i),
    .alu_exc_i      (alu_exc_i),
    .fe_pc_i        (fe_pc_i),
    .de_pc_i        (de_pc_i),
    .ex_pc_i        (ex_pc_i),
    .mem_valid_i    (mem_valid_i),
    .mem_write_i    (mem_write_i),
    .mem_size_i     (mem_size_i),
    .mem_addr_i     (mem_addr_i),
    .spec_miss_i    (spec_miss),
    .long_stall_i   (long_stall_o),
    .mispredict_pc_i(mispredict_pc),
    .mtvec_i        (mtvec_o),
    .trap_o         (trap_o),
    .trap_cause_o   (trap_cause_o),
    .trap_mepc_o    (trap_mepc_o),
    .trap_tval_o    (trap_tval_o),
    .flush_o        (trap_flush_o),
    .redirect_o     (redirect_o),
    .redirect_pc_o  (redirect_pc_o)
  );

  trap_csr #(
    .XLEN(XLEN)
  ) i_trap_csr (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pwrite_i    (pwrite_i),
    .paddr_i     (paddr_i),
    .pwdata_i    (pwdata_i),
    .prdata_o    (prdata_o),
    .pready_o    (pready_o),
    .pslverr_o   (pslverr_o),
    .trap_i      (trap_o),
    .trap_cause_i(trap_cause_o),
    .trap_mepc_i (trap_mepc_o),
    .trap_tval_i (trap_tval_o),
    .mtvec_o     (mtvec_o)
  );

endmodule

// ==== ceres_pkg.sv ====
// ==========================================================
// Ceres pipeline controller shared definitions
// Stall, exception, forwarding and flush encodings, trap
// cause codes and the trap CSR register map
// ==========================================================
package ceres_pkg;

  // Reason the pipe holds this cycle, in priority order
  typedef enum logic [2:0] {
    NO_STALL       = 3'd0,
    FENCEI_STALL   = 3'd1,
    IMISS_STALL    = 3'd2,
    DMISS_STALL    = 3'd3,
    LOAD_RAW_STALL = 3'd4,
    ALU_STALL      = 3'd5
  } stall_e;

  // Exception kind raised by a pipe stage
  typedef enum logic [2:0] {
    NO_EXCEPTION        = 3'd0,
    INSTR_MISALIGNED    = 3'd1,
    ILLEGAL_INSTRUCTION = 3'd2,
    LOAD_MISALIGNED     = 3'd3,
    STORE_MISALIGNED    = 3'd4
  } exc_e;

  // Execute operand source
  typedef enum logic [1:0] {
    FWD_NONE = 2'b00,
    FWD_WB   = 2'b01,
    FWD_MEM  = 2'b10
  } fwd_e;

  // How deep a trap flushes the pipe
  typedef enum logic [1:0] {
    FLUSH_NONE   = 2'd0,
    FLUSH_FE_DE  = 2'd2,
    FLUSH_TO_MEM = 2'd3
  } flush_e;

  // mcause codes for synchronous exceptions
  localparam logic [31:0] CAUSE_INSTR_MISALIGNED = 32'd0;
  localparam logic [31:0] CAUSE_ILLEGAL_INSTR    = 32'd2;
  localparam logic [31:0] CAUSE_LOAD_MISALIGNED  = 32'd4;
  localparam logic [31:0] CAUSE_STORE_MISALIGNED = 32'd6;

  // APB register map, byte offsets
  localparam int unsigned APB_AW = 12;
  localparam logic [APB_AW-1:0] CSR_MTVEC   = 12'h000;
  localparam logic [APB_AW-1:0] CSR_MEPC    = 12'h004;
  localparam logic [APB_AW-1:0] CSR_MCAUSE  = 12'h008;
  localparam logic [APB_AW-1:0] CSR_MTVAL   = 12'h00C;
  localparam logic [APB_AW-1:0] CSR_TRAPCNT = 12'h010;

  // Exception kind to mcause value, zero when nothing is raised
  function automatic logic [31:0] exc_to_cause(exc_e exc);
    case (exc)
      INSTR_MISALIGNED:    return CAUSE_INSTR_MISALIGNED;
      ILLEGAL_INSTRUCTION: return CAUSE_ILLEGAL_INSTR;
      LOAD_MISALIGNED:     return CAUSE_LOAD_MISALIGNED;
      STORE_MISALIGNED:    return CAUSE_STORE_MISALIGNED;
      default:             return 32'd0;
    endcase
  endfunction

endpackage

// ==== hazard_unit.sv ====
// ==========================================================
// Hazard unit
// Stall priority, load-use detection, operand forwarding and
// branch misprediction flushes
// ==========================================================
`timescale 1ns/1ps
module hazard_unit
  import ceres_pkg::*;
#(
  parameter int unsigned XLEN = 32
) (
  input  logic [4:0]      r1_addr_de_i,
  input  logic [4:0]      r2_addr_de_i,
  input  logic [4:0]      r1_addr_ex_i,
  input  logic [4:0]      r2_addr_ex_i,
  input  logic [4:0]      rd_addr_ex_i,
  input  logic [4:0]      rd_addr_me_i,
  input  logic [4:0]      rd_addr_wb_i,
  input  logic            ld_ex_i,
  input  logic            rf_rw_me_i,
  input  logic            rf_rw_wb_i,
  input  logic            br_taken_ex_i,
  input  logic            pred_taken_ex_i,
  input  logic [XLEN-1:0] br_target_ex_i,
  input  logic [XLEN-1:0] pred_pc_ex_i,
  input  logic [XLEN-1:0] pc_incr_ex_i,
  input  logic            fencei_req_i,
  input  logic            imiss_req_i,
  input  logic            dmiss_req_i,
  input  logic            alu_req_i,
  output stall_e          stall_o,
  output logic            long_stall_o,
  output logic            flush_de_o,
  output logic            flush_ex_o,
  output fwd_e            fwd_a_ex_o,
  output fwd_e            fwd_b_ex_o,
  output logic            fwd_a_de_o,
  output logic            fwd_b_de_o,
  output logic            spec_miss_o,
  output logic [XLEN-1:0] mispredict_pc_o
);

  logic load_use;
  logic mispredict;

  // Memory result is younger, so it wins over writeback
  function automatic fwd_e fwd_sel(logic [4:0] rs);
    if (rf_rw_me_i && (rd_addr_me_i != 5'd0) && (rd_addr_me_i == rs)) begin
      return FWD_MEM;
    end
    if (rf_rw_wb_i && (rd_addr_wb_i != 5'd0) && (rd_addr_wb_i == rs)) begin
      return FWD_WB;
    end
    return FWD_NONE;
  endfunction

  // ==========================================================
  // Stall cause
  // ==========================================================
  // Load in execute feeding the instruction in decode
  assign load_use = ld_ex_i && (rd_addr_ex_i != 5'd0) &&
                    ((rd_addr_ex_i == r1_addr_de_i) || (rd_addr_ex_i == r2_addr_de_i));

  always_comb begin
    if (fencei_req_i) stall_o = FENCEI_STALL;
    else if (imiss_req_i) stall_o = IMISS_STALL;
    else if (dmiss_req_i) stall_o = DMISS_STALL;
    else if (load_use) stall_o = LOAD_RAW_STALL;
    else if (alu_req_i) stall_o = ALU_STALL;
    else stall_o = NO_STALL;
  end

  // Every stall except load-use freezes the whole pipe
  assign long_stall_o = (stall_o != NO_STALL) && (stall_o != LOAD_RAW_STALL);

  // ==========================================================
  // Branch check and flushes
  // ==========================================================
  // Taken needs the right direction and the right target
  assign mispredict = br_taken_ex_i ?
                      (!pred_taken_ex_i || (pred_pc_ex_i != br_target_ex_i)) :
                      pred_taken_ex_i;

  assign spec_miss_o     = mispredict;
  assign mispredict_pc_o = br_taken_ex_i ? br_target_ex_i : pc_incr_ex_i;

  // A frozen pipe keeps its stages, flushes wait for the stall to end
  assign flush_de_o = mispredict && !long_stall_o;
  // Load-use also inserts a bubble into execute
  assign flush_ex_o = (mispredict || load_use) && !long_stall_o;

  // ==========================================================
  // Forwarding
  // ==========================================================
  // Selects follow the stage write enables and addresses as well
  always_comb begin
    fwd_a_ex_o = fwd_sel(r1_addr_ex_i);
    fwd_b_ex_o = fwd_sel(r2_addr_ex_i);
  end

  // Register file write-through for the decode read ports
  assign fwd_a_de_o = rf_rw_wb_i && (rd_addr_wb_i != 5'd0) && (rd_addr_wb_i == r1_addr_de_i);
  assign fwd_b_de_o = rf_rw_wb_i && (rd_addr_wb_i != 5'd0) && (rd_addr_wb_i == r2_addr_de_i);

  // x0 is hardwired, a memory bypass for it would corrupt an operand
  always_comb begin
    assert ((fwd_a_ex_o != FWD_MEM || r1_addr_ex_i != 5'd0) &&
            (fwd_b_ex_o != FWD_MEM || r2_addr_ex_i != 5'd0))
      else $error("hazard_unit: memory bypass selected for x0");
  end

endmodule

// ==== sources.f ====
ceres_pkg.sv
hazard_unit.sv
trap_unit.sv
trap_csr.sv
ceres_pipe_ctrl.sv
tb_ceres_pipe_ctrl.sv

// ==== tb_ceres_pipe_ctrl.sv ====
// ==========================================================
// Testbench for the Ceres pipeline controller
// Random stage facts against a reference model of the stall,
// forwarding, branch and trap rules, plus APB CSR accesses
// ==========================================================
`timescale 1ns/1ps
module tb_ceres_pipe_ctrl
  import ceres_pkg::*;
();

  localparam int unsigned XLEN        = 32;
  localparam int unsigned RAND_CYCLES = 1500;
  localparam int unsigned APB_TIMEOUT = 16;

  // DUT signals carry the port names so the instance can use .*
  logic              clk_i;
  logic              rst_ni;
  logic [4:0]        r1_addr_de_i, r2_addr_de_i, r1_addr_ex_i, r2_addr_ex_i;
  logic [4:0]        rd_addr_ex_i, rd_addr_me_i, rd_addr_wb_i;
  logic              ld_ex_i, rf_rw_me_i, rf_rw_wb_i;
  logic              br_taken_ex_i, pred_taken_ex_i;
  logic [XLEN-1:0]   br_target_ex_i, pred_pc_ex_i, pc_incr_ex_i;
  logic              fencei_req_i, imiss_req_i, dmiss_req_i, alu_req_i;
  exc_e              fe_exc_i, de_exc_i, alu_exc_i;
  logic [XLEN-1:0]   fe_pc_i, de_pc_i, ex_pc_i;
  logic              mem_valid_i, mem_write_i;
  logic [1:0]        mem_size_i;
  logic [XLEN-1:0]   mem_addr_i;
  logic              psel_i, penable_i, pwrite_i;
  logic [APB_AW-1:0] paddr_i;
  logic [XLEN-1:0]   pwdata_i, prdata_o;
  logic              pready_o, pslverr_o;
  stall_e            stall_o;
  logic              long_stall_o, flush_de_o, flush_ex_o;
  fwd_e              fwd_a_ex_o, fwd_b_ex_o;
  logic              fwd_a_de_o, fwd_b_de_o;
  logic              trap_o, redirect_o;
  logic [XLEN-1:0]   trap_cause_o, trap_mepc_o, trap_tval_o, redirect_pc_o, mtvec_o;
  flush_e            trap_flush_o;

  integer seed = 32'had62;

  // Reference state of the CSR block
  logic [XLEN-1:0] mtvec_mdl, mepc_mdl, mcause_mdl, mtval_mdl, trap_cnt_mdl;
  // Trap expected in the current cycle, captured at the next edge
  logic            exp_trap;
  logic [XLEN-1:0] exp_cause, exp_mepc, exp_tval;

  ceres_pipe_ctrl #(
    .XLEN(XLEN)
  ) i_dut (.*);

  always #20 clk_i = ~clk_i;

  // ==========================================================
  // Compare tasks
  // ==========================================================
  task automatic abort_run();
    $display("Test FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_stall(input string name, input stall_e exp, input stall_e act);
    if (act !== exp) begin
      $display("[ERROR] %0t ns %s expected %s got %s", $time, name, exp.name(), act.name());
      abort_run();
    end
  endtask

  task automatic check_fwd(input string name, input fwd_e exp, input fwd_e act);
    if (act !== exp) begin
      $display("[ERROR] %0t ns %s expected %s got %s", $time, name, exp.name(), act.name());
      abort_run();
    end
  endtask

  task automatic check_flush(input string name, input flush_e exp, input flush_e act);
    if (act !== exp) begin
      $display("[ERROR] %0t ns %s expected %s got %s", $time, name, exp.name(), act.name());
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %0t ns %s expected %b got %b", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_word(input string name, input logic [XLEN-1:0] exp,
                            input logic [XLEN-1:0] act);
    if (act !== exp) begin
      $display("[ERROR] %0t ns %s expected %h got %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  // ==========================================================
  // Reference model
  // ==========================================================
  function automatic logic load_use_hit();
    return ld_ex_i && (rd_addr_ex_i != 5'd0) &&
           ((rd_addr_ex_i == r1_addr_de_i) || (rd_addr_ex_i == r2_addr_de_i));
  endfunction

  // Fixed order fencei, imiss, dmiss, load-use, alu
  function automatic stall_e expected_stall();
    if (fencei_req_i) return FENCEI_STALL;
    if (imiss_req_i) return IMISS_STALL;
    if (dmiss_req_i) return DMISS_STALL;
    if (load_use_hit()) return LOAD_RAW_STALL;
    if (alu_req_i) return ALU_STALL;
    return NO_STALL;
  endfunction

  function automatic fwd_e expected_fwd(input logic [4:0] rs);
    if (rf_rw_me_i && rd_addr_me_i != 5'd0 && rd_addr_me_i == rs) return FWD_MEM;
    if (rf_rw_wb_i && rd_addr_wb_i != 5'd0 && rd_addr_wb_i == rs) return FWD_WB;
    return FWD_NONE;
  endfunction

  function automatic logic wb_bypass(input logic [4:0] rs);
    return rf_rw_wb_i && (rd_addr_wb_i != 5'd0) && (rd_addr_wb_i == rs);
  endfunction

  function automatic logic branch_missed();
    if (br_taken_ex_i) return !pred_taken_ex_i || (pred_pc_ex_i != br_target_ex_i);
    return pred_taken_ex_i;
  endfunction

  // ALU fault first, then halfword and word alignment
  function automatic exc_e execute_exc();
    logic bad;
    bad = ((mem_size_i == 2'd2) && mem_addr_i[0]) ||
          ((mem_size_i == 2'd3) && (mem_addr_i[1:0] != 2'b00));
    if (alu_exc_i != NO_EXCEPTION) return alu_exc_i;
    if (mem_valid_i && bad) return mem_write_i ? STORE_MISALIGNED : LOAD_MISALIGNED;
    return NO_EXCEPTION;
  endfunction

  // RISC-V mcause numbering
  function automatic logic [XLEN-1:0] cause_code(input exc_e exc);
    case (exc)
      INSTR_MISALIGNED:    return 32'd0;
      ILLEGAL_INSTRUCTION: return 32'd2;
      LOAD_MISALIGNED:     return 32'd4;
      STORE_MISALIGNED:    return 32'd6;
      default:             return 32'd0;
    endcase
  endfunction

  function automatic exc_e random_exc(input logic [3:0] r);
    if (r < 4'd5) return exc_e'(r[2:0]);
    return NO_EXCEPTION;
  endfunction

  function automatic logic addr_listed(input logic [APB_AW-1:0] addr);
    return (addr == CSR_MTVEC) || (addr == CSR_MEPC) || (addr == CSR_MCAUSE) ||
           (addr == CSR_MTVAL) || (addr == CSR_TRAPCNT);
  endfunction

  function automatic logic [XLEN-1:0] model_reg(input logic [APB_AW-1:0] addr);
    case (addr)
      CSR_MTVEC:   return mtvec_mdl;
      CSR_MEPC:    return mepc_mdl;
      CSR_MCAUSE:  return mcause_mdl;
      CSR_MTVAL:   return mtval_mdl;
      CSR_TRAPCNT: return trap_cnt_mdl;
      default:     return '0;
    endcase
  endfunction

  // ==========================================================
  // Stimulus and per-cycle check
  // ==========================================================
  task automatic quiet_inputs();
    {r1_addr_de_i, r2_addr_de_i, r1_addr_ex_i, r2_addr_ex_i} = '0;
    {rd_addr_ex_i, rd_addr_me_i, rd_addr_wb_i} = '0;
    {ld_ex_i, rf_rw_me_i, rf_rw_wb_i, br_taken_ex_i, pred_taken_ex_i} = '0;
    {br_target_ex_i, pred_pc_ex_i, pc_incr_ex_i} = '0;
    {fencei_req_i, imiss_req_i, dmiss_req_i, alu_req_i} = '0;
    fe_exc_i  = NO_EXCEPTION;
    de_exc_i  = NO_EXCEPTION;
    alu_exc_i = NO_EXCEPTION;
    {fe_pc_i, de_pc_i, ex_pc_i, mem_addr_i} = '0;
    {mem_valid_i, mem_write_i, mem_size_i} = '0;
    {psel_i, penable_i, pwrite_i, paddr_i, pwdata_i} = '0;
  endtask

  task automatic drive_random();
    logic [31:0] rnd;
    rnd = $random(seed);
    // Only x0..x7 so that address matches are frequent
    r1_addr_de_i    = {2'b00, rnd[2:0]};
    r2_addr_de_i    = {2'b00, rnd[5:3]};
    r1_addr_ex_i    = {2'b00, rnd[8:6]};
    r2_addr_ex_i    = {2'b00, rnd[11:9]};
    rd_addr_ex_i    = {2'b00, rnd[14:12]};
    rd_addr_me_i    = {2'b00, rnd[17:15]};
    rd_addr_wb_i    = {2'b00, rnd[20:18]};
    ld_ex_i         = rnd[21];
    rf_rw_me_i      = rnd[22];
    rf_rw_wb_i      = rnd[23];
    br_taken_ex_i   = rnd[24];
    pred_taken_ex_i = rnd[25];
    // Rare stall requests leave room for flushes
    fencei_req_i    = (rnd[28:26] == 3'd0);
    imiss_req_i     = (rnd[31:29] == 3'd0);
    rnd = $random(seed);
    dmiss_req_i     = (rnd[2:0] == 3'd0);
    alu_req_i       = (rnd[5:3] == 3'd0);
    fe_exc_i        = random_exc(rnd[9:6]);
    de_exc_i        = random_exc(rnd[13:10]);
    alu_exc_i       = random_exc(rnd[17:14]);
    mem_valid_i     = rnd[18];
    mem_write_i     = rnd[19];
    mem_size_i      = rnd[21:20];
    mem_addr_i      = $random(seed);
    br_target_ex_i  = $random(seed);
    // Half the predictions point at the real target
    pred_pc_ex_i    = rnd[22] ? br_target_ex_i : $random(seed);
    pc_incr_ex_i    = $random(seed);
    fe_pc_i         = $random(seed);
    de_pc_i         = $random(seed);
    ex_pc_i         = $random(seed);
  endtask

  task automatic check_cycle();
    stall_e          stall_exp;
    logic            long_exp;
    logic            miss;
    exc_e            ex_exc;
    exc_e            win;
    flush_e          flush_exp;
    logic [XLEN-1:0] redir_pc;
    stall_exp = expected_stall();
    long_exp  = (stall_exp != NO_STALL) && (stall_exp != LOAD_RAW_STALL);
    miss      = branch_missed();
    check_stall("stall_o", stall_exp, stall_o);
    check_bit("long_stall_o", long_exp, long_stall_o);
    check_bit("flush_de_o", miss && !long_exp, flush_de_o);
    check_bit("flush_ex_o", (miss || load_use_hit()) && !long_exp, flush_ex_o);
    check_fwd("fwd_a_ex_o", expected_fwd(r1_addr_ex_i), fwd_a_ex_o);
    check_fwd("fwd_b_ex_o", expected_fwd(r2_addr_ex_i), fwd_b_ex_o);
    check_bit("fwd_a_de_o", wb_bypass(r1_addr_de_i), fwd_a_de_o);
    check_bit("fwd_b_de_o", wb_bypass(r2_addr_de_i), fwd_b_de_o);
    // Execute, then decode, then fetch, younger ones masked on a miss
    ex_exc    = execute_exc();
    win       = NO_EXCEPTION;
    flush_exp = FLUSH_NONE;
    exp_mepc  = '0;
    if (ex_exc != NO_EXCEPTION) begin
      win       = ex_exc;
      exp_mepc  = ex_pc_i;
      flush_exp = FLUSH_TO_MEM;
    end else if (!miss && de_exc_i != NO_EXCEPTION) begin
      win       = de_exc_i;
      exp_mepc  = de_pc_i;
      flush_exp = FLUSH_FE_DE;
    end else if (!miss && fe_exc_i != NO_EXCEPTION) begin
      win       = fe_exc_i;
      exp_mepc  = fe_pc_i;
    end
    exp_trap  = (win != NO_EXCEPTION);
    exp_cause = cause_code(win);
    if (win == LOAD_MISALIGNED || win == STORE_MISALIGNED) exp_tval = mem_addr_i;
    else if (win == INSTR_MISALIGNED) exp_tval = exp_mepc;
    else exp_tval = '0;
    check_bit("trap_o", exp_trap, trap_o);
    check_flush("trap_flush_o", flush_exp, trap_flush_o);
    if (exp_trap) begin
      check_word("trap_cause_o", exp_cause, trap_cause_o);
      check_word("trap_mepc_o", exp_mepc, trap_mepc_o);
      check_word("trap_tval_o", exp_tval, trap_tval_o);
    end
    redir_pc = exp_trap ? mtvec_mdl : (br_taken_ex_i ? br_target_ex_i : pc_incr_ex_i);
    check_bit("redirect_o", exp_trap || (miss && !long_exp), redirect_o);
    if (redirect_o) check_word("redirect_pc_o", redir_pc, redirect_pc_o);
    check_word("mtvec_o", mtvec_mdl, mtvec_o);
  endtask

  // Starts and ends 2 ns after a rising edge
  task automatic run_random(input int unsigned cycles);
    for (int unsigned n = 0; n < cycles; n++) begin
      drive_random();
      #30;
      check_cycle();
      @(posedge clk_i);
      if (exp_trap) begin
        mepc_mdl     = exp_mepc;
        mcause_mdl   = exp_cause;
        mtval_mdl    = exp_tval;
        trap_cnt_mdl = trap_cnt_mdl + 1'b1;
      end
      #2;
    end
  endtask

  // ==========================================================
  // APB transfer, setup then access with a bounded ready wait
  // ==========================================================
  task automatic apb_transfer(input logic write, input logic [APB_AW-1:0] addr,
                              input logic [XLEN-1:0] wdata);
    int unsigned     waited;
    logic            exp_err;
    logic [XLEN-1:0] exp_rdata;
    exp_err   = !addr_listed(addr);
    exp_rdata = model_reg(addr);
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = write;
    paddr_i   = addr;
    pwdata_i  = wdata;
    @(posedge clk_i);
    #2;
    penable_i = 1'b1;
    #30;
    waited = 0;
    while (pready_o !== 1'b1) begin
      waited++;
      if (waited > APB_TIMEOUT) begin
        $display("APB transfer to address %h never got pready", addr);
        abort_run();
      end
      @(posedge clk_i);
      #32;
    end
    check_bit("pslverr_o", exp_err, pslverr_o);
    if (!write && !exp_err) check_word("prdata_o", exp_rdata, prdata_o);
    @(posedge clk_i);
    // Only mtvec takes writes, low bits forced clear
    if (write && !exp_err && addr == CSR_MTVEC) mtvec_mdl = {wdata[XLEN-1:2], 2'b00};
    #2;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic read_trap_regs();
    apb_transfer(1'b0, CSR_MEPC, '0);
    apb_transfer(1'b0, CSR_MCAUSE, '0);
    apb_transfer(1'b0, CSR_MTVAL, '0);
    apb_transfer(1'b0, CSR_TRAPCNT, '0);
  endtask

  // ==========================================================
  // Main sequence
  // ==========================================================
  initial begin
    clk_i  = 1'b0;
    rst_ni = 1'b0;
    quiet_inputs();
    {mtvec_mdl, mepc_mdl, mcause_mdl, mtval_mdl, trap_cnt_mdl} = '0;
    {exp_trap, exp_cause, exp_mepc, exp_tval} = '0;
    repeat (8) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    // Everything reads zero out of reset
    apb_transfer(1'b0, CSR_MTVEC, '0);
    read_trap_regs();
    for (int round = 0; round < 2; round++) begin
      apb_transfer(1'b1, CSR_MTVEC, $random(seed));
      apb_transfer(1'b0, CSR_MTVEC, '0);
      run_random(RAND_CYCLES);
      quiet_inputs();
      read_trap_regs();
    end
    // Misaligned and unlisted offsets answer with an error
    apb_transfer(1'b1, 12'h002, 32'hffff_fff0);
    apb_transfer(1'b0, CSR_MTVEC, '0);
    apb_transfer(1'b0, 12'h014, '0);
    apb_transfer(1'b0, 12'h00D, '0);
    apb_transfer(1'b1, 12'h7FC, 32'h0bad_0bad);
    // Capture registers ignore writes
    apb_transfer(1'b1, CSR_MEPC, 32'h1234_5678);
    apb_transfer(1'b1, CSR_TRAPCNT, 32'h0000_00ff);
    read_trap_regs();
    $display("Test OK");
    $finish;
  end

endmodule

// ==== trap_csr.sv ====
// ==========================================================
// Trap CSR block
// APB completer with a writable trap vector and read-only
// capture of the last trap plus a trap counter
// ==========================================================
`timescale 1ns/1ps
module trap_csr
  import ceres_pkg::*;
#(
  parameter int unsigned XLEN = 32
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  logic [APB_AW-1:0] paddr_i,
  input  logic [XLEN-1:0]   pwdata_i,
  output logic [XLEN-1:0]   prdata_o,
  output logic              pready_o,
  output logic              pslverr_o,
  input  logic              trap_i,
  input  logic [XLEN-1:0]   trap_cause_i,
  input  logic [XLEN-1:0]   trap_mepc_i,
  input  logic [XLEN-1:0]   trap_tval_i,
  output logic [XLEN-1:0]   mtvec_o
);

  logic [XLEN-1:0] mtvec_q;
  logic [XLEN-1:0] mepc_q;
  logic [XLEN-1:0] mcause_q;
  logic [XLEN-1:0] mtval_q;
  logic [XLEN-1:0] trap_cnt_q;
  logic            access;
  logic            addr_hit;
  logic            mtvec_we;

  // ==========================================================
  // APB decode
  // ==========================================================
  // No wait states, every access completes in one cycle
  assign pready_o = 1'b1;
  assign access   = psel_i && penable_i;

  // Only listed word offsets respond
  always_comb begin
    case (paddr_i)
      CSR_MTVEC,
      CSR_MEPC,
      CSR_MCAUSE,
      CSR_MTVAL,
      CSR_TRAPCNT: addr_hit = 1'b1;
      default:     addr_hit = 1'b0;
    endcase
  end

  assign pslverr_o = access && !addr_hit;
  // Writes to the capture registers are dropped silently
  assign mtvec_we  = access && pwrite_i && (paddr_i == CSR_MTVEC);

  always_comb begin
    case (paddr_i)
      CSR_MTVEC:   prdata_o = mtvec_q;
      CSR_MEPC:    prdata_o = mepc_q;
      CSR_MCAUSE:  prdata_o = mcause_q;
      CSR_MTVAL:   prdata_o = mtval_q;
      CSR_TRAPCNT: prdata_o = trap_cnt_q;
      default:     prdata_o = '0;
    endcase
  end

  // ==========================================================
  // Registers
  // ==========================================================
  // Direct mode only, vector kept word aligned
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      mtvec_q <= '0;
    end else if (mtvec_we) begin
      mtvec_q <= {pwdata_i[XLEN-1:2], 2'b00};
    end
  end

  // Capture the trap seen in this cycle
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      mepc_q     <= '0;
      mcause_q   <= '0;
      mtval_q    <= '0;
      trap_cnt_q <= '0;
    end else if (trap_i) begin
      mepc_q     <= trap_mepc_i;
      mcause_q   <= trap_cause_i;
      mtval_q    <= trap_tval_i;
      trap_cnt_q <= trap_cnt_q + 1'b1;
    end
  end

  // Redirect uses the stored vector, a new write lands next cycle
  assign mtvec_o = mtvec_q;

  // APB access phase is only legal inside a selected transfer
  a_penable_in_psel : assert property (
    @(posedge clk_i) disable iff (!rst_ni) penable_i |-> psel_i
  ) else $error("trap_csr: penable without psel");

endmodule

// ==== trap_unit.sv ====
// ==========================================================
// Trap unit
// Access misalignment check, exception priority across
// execute, decode and fetch, trap info and fetch redirect
// ==========================================================
`timescale 1ns/1ps
module trap_unit
  import ceres_pkg::*;
#(
  parameter int unsigned XLEN = 32
) (
  input  exc_e            fe_exc_i,
  input  exc_e            de_exc_i,
  input  exc_e            alu_exc_i,
  input  logic [XLEN-1:0] fe_pc_i,
  input  logic [XLEN-1:0] de_pc_i,
  input  logic [XLEN-1:0] ex_pc_i,
  input  logic            mem_valid_i,
  input  logic            mem_write_i,
  input  logic [1:0]      mem_size_i,
  input  logic [XLEN-1:0] mem_addr_i,
  input  logic            spec_miss_i,
  input  logic            long_stall_i,
  input  logic [XLEN-1:0] mispredict_pc_i,
  input  logic [XLEN-1:0] mtvec_i,
  output logic            trap_o,
  output logic [XLEN-1:0] trap_cause_o,
  output logic [XLEN-1:0] trap_mepc_o,
  output logic [XLEN-1:0] trap_tval_o,
  output flush_e          flush_o,
  output logic            redirect_o,
  output logic [XLEN-1:0] redirect_pc_o
);

  exc_e ex_exc;
  exc_e de_act;
  exc_e fe_act;
  exc_e win_exc;
  logic misaligned;

  // ==========================================================
  // Execute exception
  // ==========================================================
  // Halfword needs bit 0 clear, word needs both low bits clear
  always_comb begin
    case (mem_size_i)
      2'd2:    misaligned = mem_addr_i[0];
      2'd3:    misaligned = |mem_addr_i[1:0];
      default: misaligned = 1'b0;
    endcase
  end

  // ALU fault wins over the access check of the same instruction
  always_comb begin
    if (alu_exc_i != NO_EXCEPTION) begin
      ex_exc = alu_exc_i;
    end else if (mem_valid_i && misaligned) begin
      ex_exc = mem_write_i ? STORE_MISALIGNED : LOAD_MISALIGNED;
    end else begin
      ex_exc = NO_EXCEPTION;
    end
  end

  // Younger stages sit on the wrong path after a mispredict
  assign de_act = spec_miss_i ? NO_EXCEPTION : de_exc_i;
  assign fe_act = spec_miss_i ? NO_EXCEPTION : fe_exc_i;

  // ==========================================================
  // Priority select
  // ==========================================================
  always_comb begin
    if (ex_exc != NO_EXCEPTION) begin
      win_exc     = ex_exc;
      trap_mepc_o = ex_pc_i;
      flush_o     = FLUSH_TO_MEM;
    end else if (de_act != NO_EXCEPTION) begin
      win_exc     = de_act;
      trap_mepc_o = de_pc_i;
      flush_o     = FLUSH_FE_DE;
    end else if (fe_act != NO_EXCEPTION) begin
      win_exc     = fe_act;
      trap_mepc_o = fe_pc_i;
      flush_o     = FLUSH_NONE;
    end else begin
      win_exc     = NO_EXCEPTION;
      trap_mepc_o = ex_pc_i;
      flush_o     = FLUSH_NONE;
    end
  end

  assign trap_o       = (win_exc != NO_EXCEPTION);
  assign trap_cause_o = XLEN'(exc_to_cause(win_exc));

  // mtval holds the faulting address or pc, zero for illegal
  always_comb begin
    case (win_exc)
      LOAD_MISALIGNED,
      STORE_MISALIGNED: trap_tval_o = mem_addr_i;
      INSTR_MISALIGNED: trap_tval_o = trap_mepc_o;
      default:          trap_tval_o = '0;
    endcase
  end

  // ==========================================================
  // Redirect
  // ==========================================================
  // Trap vector first, then the corrected branch path
  always_comb begin
    if (trap_o) begin
      redirect_o    = 1'b1;
      redirect_pc_o = mtvec_i;
    end else begin
      redirect_o    = spec_miss_i && !long_stall_i;
      redirect_pc_o = mispredict_pc_i;
    end
  end

  // An execute trap has to clear the pipe down to memory
  always_comb begin
    assert ((flush_o == FLUSH_TO_MEM) == (trap_o && ex_exc != NO_EXCEPTION))
      else $error("trap_unit: execute trap and flush depth disagree");
  end

endmodule
